/* design/ex_params.svh */
// Execute stage widths shared by packages, RTL and testbench
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// One machine word, data and addresses alike
`define EX_XLEN 32

// Scoreboard entry tag carried with every issue
`define EX_TRANS_ID_BITS 3

// Standard RISC-V CSR address field
`define EX_CSR_ADDR_BITS 12

`endif

/* design/ex_types_pkg.sv */
// Issue-side types: operations, issue payload and write-back word
`default_nettype none

`include "ex_params.svh"

package ex_types_pkg;

    // ------------------------------
    // Operations
    // ------------------------------

    // ALU ops, branch compares, multiply, CSR access
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        MUL,
        CSRRW
    } fu_op_t;

    // ------------------------------
    // Issue and write-back payloads
    // ------------------------------

    // Shared issue payload, same for every unit
    typedef struct packed {
        fu_op_t                       operation;
        logic [`EX_XLEN-1:0]          operand_a;
        logic [`EX_XLEN-1:0]          operand_b;
        logic [`EX_XLEN-1:0]          imm;
        logic [`EX_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // Single write-back port into the scoreboard
    typedef struct packed {
        logic                         valid;
        logic [`EX_TRANS_ID_BITS-1:0] trans_id;
        logic [`EX_XLEN-1:0]          result;
    } wb_t;

endpackage

`default_nettype wire

/* design/ex_branch_pkg.sv */
// Branch prediction, branch resolution and exception types
`default_nettype none

`include "ex_params.svh"

package ex_branch_pkg;

    // Prediction made by the frontend
    typedef struct packed {
        logic                predict_taken;
        logic [`EX_XLEN-1:0] predict_address;
    } branch_predict_t;

    // Outcome sent back to the frontend
    typedef struct packed {
        logic                valid;
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] target_address;
        logic                is_taken;
        logic                is_mispredict;
    } bp_resolve_t;

    // Synchronous exception from the execute stage
    // Cause 0 is instruction address misaligned
    typedef struct packed {
        logic                valid;
        logic [3:0]          cause;
        logic [`EX_XLEN-1:0] tval;
    } exception_t;

endpackage

`default_nettype wire

/* design/ex_alu.sv */
// Combinational ALU with arithmetic, logic, shift, set-less-than and branch compare
`default_nettype none

`include "ex_params.svh"

module ex_alu (
    input  ex_types_pkg::fu_data_t fu_data_i,
    output logic [`EX_XLEN-1:0]    result_o,
    output logic                   branch_res_o
);

    import ex_types_pkg::*;

    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic                lt_signed;
    logic                lt_unsigned;
    logic                equal;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    // Only low 5 bits count for a 32-bit shift
    assign shamt = op_b[4:0];

    // Comparators shared by SLT* and the branch compares
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;
    assign equal       = op_a == op_b;

    // ------------------------------
    // Result mux
    // ------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operation)
            ADD:  result_o = op_a + op_b;
            SUB:  result_o = op_a - op_b;
            AND:  result_o = op_a & op_b;
            OR:   result_o = op_a | op_b;
            XOR:  result_o = op_a ^ op_b;
            SLL:  result_o = op_a << shamt;
            SRL:  result_o = op_a >> shamt;
            SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            // Compares, MUL and CSRRW leave the result at zero
            default: result_o = '0;
        endcase
    end

    // ------------------------------
    // Branch compare
    // ------------------------------
    always_comb begin
        branch_res_o = 1'b0;
        case (fu_data_i.operation)
            EQ:  branch_res_o = equal;
            NE:  branch_res_o = ~equal;
            LT:  branch_res_o = lt_signed;
            GE:  branch_res_o = ~lt_signed;
            LTU: branch_res_o = lt_unsigned;
            GEU: branch_res_o = ~lt_unsigned;
            default: branch_res_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_branch_unit.sv */
// Branch unit computing link address, target, mispredict and misaligned-target exception
`default_nettype none

`include "ex_params.svh"

module ex_branch_unit (
    input  ex_types_pkg::fu_data_t         fu_data_i,
    input  logic [`EX_XLEN-1:0]            pc_i,
    input  logic                           is_compressed_i,
    input  logic                           branch_valid_i,
    input  logic                           branch_res_i,
    input  ex_branch_pkg::branch_predict_t branch_predict_i,
    output logic [`EX_XLEN-1:0]            link_o,
    output ex_branch_pkg::bp_resolve_t     resolved_branch_o,
    output logic                           resolve_branch_o,
    output ex_branch_pkg::exception_t      branch_exception_o
);

    import ex_types_pkg::*;
    import ex_branch_pkg::*;

    logic [`EX_XLEN-1:0] pc_step;
    logic [`EX_XLEN-1:0] target;
    logic                mispredict;

    // Compressed instructions are 2 bytes long
    assign pc_step = is_compressed_i ? `EX_XLEN'(2) : `EX_XLEN'(4);
    assign link_o  = pc_i + pc_step;

    // Not taken falls through to the link address
    assign target = branch_res_i ? (pc_i + fu_data_i.imm) : link_o;

    // Wrong direction or wrong next address
    assign mispredict = (branch_predict_i.predict_taken != branch_res_i)
                      | (branch_predict_i.predict_address != target);

    // ------------------------------
    // Resolution to the frontend
    // ------------------------------
    always_comb begin
        resolved_branch_o.valid          = branch_valid_i;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.target_address = target;
        resolved_branch_o.is_taken       = branch_valid_i & branch_res_i;
        resolved_branch_o.is_mispredict  = branch_valid_i & mispredict;
    end

    // One pulse per issued branch
    assign resolve_branch_o = branch_valid_i;

    // ------------------------------
    // Misaligned target
    // ------------------------------
    // Halfword alignment is enough with compressed support
    always_comb begin
        branch_exception_o.valid = branch_valid_i & branch_res_i & target[0];
        branch_exception_o.cause = 4'd0;
        branch_exception_o.tval  = target;
    end

endmodule

`default_nettype wire

/* design/ex_csr_buffer.sv */
// Single-entry CSR buffer holding the address until commit or flush
`default_nettype none

`include "ex_params.svh"

module ex_csr_buffer (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         csr_valid_i,
    input  logic                         csr_commit_i,
    input  ex_types_pkg::fu_data_t       fu_data_i,
    output logic                         full_o,
    output logic [`EX_XLEN-1:0]          csr_result_o,
    output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o
);

    import ex_types_pkg::*;

    logic                         full_q;
    logic [`EX_CSR_ADDR_BITS-1:0] addr_q;

    // Write data goes straight to write-back, the CSR file reads it at commit
    assign csr_result_o = fu_data_i.operand_a;

    // Occupancy flag
    // Issue is blocked while full, so no new entry collides with commit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address field from operand_b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b[`EX_CSR_ADDR_BITS-1:0];
        end
    end

    assign full_o     = full_q;
    assign csr_addr_o = addr_q;

endmodule

`default_nettype wire

/* design/ex_mult.sv */
// One-cycle multiplier returning the low word of the product with its transaction ID
`default_nettype none

`include "ex_params.svh"

module ex_mult (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         mult_valid_i,
    input  ex_types_pkg::fu_data_t       fu_data_i,
    output logic                         mult_valid_o,
    output logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id_o,
    output logic [`EX_XLEN-1:0]          mult_result_o
);

    import ex_types_pkg::*;

    logic [`EX_XLEN-1:0]          product_lo;
    logic                         valid_q;
    logic [`EX_TRANS_ID_BITS-1:0] trans_id_q;
    logic [`EX_XLEN-1:0]          result_q;

    // ------------------------------
    // Product
    // ------------------------------
    // Low word is the same for signed and unsigned operands
    assign product_lo = fu_data_i.operand_a * fu_data_i.operand_b;

    // ------------------------------
    // Output stage
    // ------------------------------
    // Flush in the issue cycle kills the result
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    // Payload only loads on issue
    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= product_lo;
            trans_id_q <= fu_data_i.trans_id;
        end
    end

    // Valid lasts one cycle, so a new issue fits right after write-back
    assign mult_valid_o    = valid_q;
    assign mult_trans_id_o = trans_id_q;
    assign mult_result_o   = result_q;

endmodule

`default_nettype wire

/* design/ex_flu_ctrl.sv */
// Fixed-latency unit control: input silencing, issue ready and write-back select
`default_nettype none

`include "ex_params.svh"

module ex_flu_ctrl (
    input  logic                         alu_valid_i,
    input  logic                         branch_valid_i,
    input  logic                         csr_valid_i,
    input  logic                         mult_valid_i,
    input  ex_types_pkg::fu_data_t       fu_data_i,
    input  logic [`EX_XLEN-1:0]          alu_result_i,
    input  logic [`EX_XLEN-1:0]          branch_result_i,
    input  logic [`EX_XLEN-1:0]          csr_result_i,
    input  logic [`EX_XLEN-1:0]          mult_result_i,
    input  logic                         csr_full_i,
    input  logic                         mult_valid_i_r,
    input  logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id_i,
    output ex_types_pkg::fu_data_t       alu_data_o,
    output ex_types_pkg::fu_data_t       mult_data_o,
    output ex_types_pkg::wb_t            flu_wb_o,
    output logic                         flu_ready_o
);

    import ex_types_pkg::*;

    // ------------------------------
    // Input silencing
    // ------------------------------
    // ALU also serves the branch compares
    assign alu_data_o  = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign mult_data_o = mult_valid_i ? fu_data_i : '0;

    // ------------------------------
    // Write-back select
    // ------------------------------
    always_comb begin
        flu_wb_o.valid    = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i_r;
        // Branch link is the default result
        flu_wb_o.result   = branch_result_i;
        flu_wb_o.trans_id = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_wb_o.result = alu_result_i;
        end else if (csr_valid_i) begin
            flu_wb_o.result = csr_result_i;
        end else if (mult_valid_i_r) begin
            // Delayed result carries its own tag
            flu_wb_o.result   = mult_result_i;
            flu_wb_o.trans_id = mult_trans_id_i;
        end
    end

    // ------------------------------
    // Issue ready
    // ------------------------------
    // Hold off while the CSR entry waits or the multiplier owns the port
    assign flu_ready_o = ~csr_full_i & ~mult_valid_i_r;

endmodule

`default_nettype wire

/* design/ex_stage.sv */
// Execute stage top: ALU, branch unit, CSR buffer and multiplier on one issue and write-back port
`default_nettype none

`include "ex_params.svh"

module ex_stage (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           flush_i,
    input  ex_types_pkg::fu_data_t         fu_data_i,
    input  logic [`EX_XLEN-1:0]            pc_i,
    input  logic                           is_compressed_i,
    input  ex_branch_pkg::branch_predict_t branch_predict_i,
    input  logic                           alu_valid_i,
    input  logic                           branch_valid_i,
    input  logic                           csr_valid_i,
    input  logic                           mult_valid_i,
    input  logic                           csr_commit_i,
    output ex_types_pkg::wb_t              flu_wb_o,
    output logic                           flu_ready_o,
    output ex_branch_pkg::bp_resolve_t     resolved_branch_o,
    output logic                           resolve_branch_o,
    output ex_branch_pkg::exception_t      flu_exception_o,
    output logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr_o
);

    import ex_types_pkg::*;

    // Silenced unit inputs
    fu_data_t                     alu_data;
    fu_data_t                     mult_data;
    // Unit results back to control
    logic [`EX_XLEN-1:0]          alu_result;
    logic                         alu_branch_res;
    logic [`EX_XLEN-1:0]          branch_link;
    logic [`EX_XLEN-1:0]          csr_result;
    logic                         csr_full;
    logic                         mult_valid;
    logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id;
    logic [`EX_XLEN-1:0]          mult_result;

    ex_flu_ctrl u_flu_ctrl (
        .alu_valid_i     (alu_valid_i),
        .branch_valid_i  (branch_valid_i),
        .csr_valid_i     (csr_valid_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (fu_data_i),
        .alu_result_i    (alu_result),
        .branch_result_i (branch_link),
        .csr_result_i    (csr_result),
        .mult_result_i   (mult_result),
        .csr_full_i      (csr_full),
        .mult_valid_i_r  (mult_valid),
        .mult_trans_id_i (mult_trans_id),
        .alu_data_o      (alu_data),
        .mult_data_o     (mult_data),
        .flu_wb_o        (flu_wb_o),
        .flu_ready_o     (flu_ready_o)
    );

    ex_alu u_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Branch unit sees the raw payload, its path is already long
    ex_branch_unit u_branch_unit (
        .fu_data_i          (fu_data_i),
        .pc_i               (pc_i),
        .is_compressed_i    (is_compressed_i),
        .branch_valid_i     (branch_valid_i),
        .branch_res_i       (alu_branch_res),
        .branch_predict_i   (branch_predict_i),
        .link_o             (branch_link),
        .resolved_branch_o  (resolved_branch_o),
        .resolve_branch_o   (resolve_branch_o),
        .branch_exception_o (flu_exception_o)
    );

    ex_csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .fu_data_i    (fu_data_i),
        .full_o       (csr_full),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    ex_mult u_mult (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (mult_data),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id),
        .mult_result_o   (mult_result)
    );

endmodule

`default_nettype wire

/* dv/ex_stage_checker.sv */
// Issue and write-back protocol assertions, bound into the FLU control
`default_nettype none

module ex_stage_checker (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   flush_i,
    input logic                   alu_valid_i,
    input logic                   branch_valid_i,
    input logic                   csr_valid_i,
    input logic                   mult_valid_i,
    input logic                   flu_ready_o,
    input ex_types_pkg::fu_data_t fu_data_i,
    input ex_types_pkg::wb_t      flu_wb_o
);

    import ex_types_pkg::*;

    logic [3:0] strobes;

    assign strobes = {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i};

    // ------------------------------
    // Issue side
    // ------------------------------
    a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(strobes))
        else $error("more than one issue strobe in a cycle");

    a_no_issue_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
        !flu_ready_o |-> strobes == 4'b0000)
        else $error("issue while flu_ready_o is low");

    // ------------------------------
    // Write-back side
    // ------------------------------
    a_idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !flu_wb_o.valid)
        else $error("write-back valid right after reset");

    // Multiply result one cycle later with its own tag
    a_mult_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        mult_valid_i && !flush_i |=>
            flu_wb_o.valid && flu_wb_o.trans_id == $past(fu_data_i.trans_id))
        else $error("multiplier write-back missing or wrong tag");

endmodule

`default_nettype wire

/* dv/tb_ex_stage.sv */
// Testbench for the execute stage: random issue stream checked against a reference model
`default_nettype none

`include "ex_params.svh"

module tb_ex_stage;

    import ex_types_pkg::*;
    import ex_branch_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int SETTLE      = CLK_PERIOD / 4;
    localparam int READY_LIMIT = 16;
    // Issue kinds used by the stimulus
    localparam int K_IDLE = 0;
    localparam int K_ALU  = 1;
    localparam int K_BR   = 2;
    localparam int K_CSR  = 3;
    localparam int K_MUL  = 4;
    // Test lengths
    localparam int N_ALU   = 60;
    localparam int N_BR    = 60;
    localparam int N_MUL   = 16;
    localparam int N_CSR   = 8;
    localparam int N_FLUSH = 4;
    localparam int N_MIX   = 300;
    localparam int TOTAL_CYCLES = 4 + N_ALU + N_BR + 2 * N_MUL + 8 * N_CSR
                                + 5 * N_FLUSH + N_MIX;

    logic                         clk_i;
    logic                         reset_i;
    logic                         flush_i;
    fu_data_t                     fu_data_i;
    logic [`EX_XLEN-1:0]          pc_i;
    logic                         is_compressed_i;
    branch_predict_t              branch_predict_i;
    logic                         alu_valid_i;
    logic                         branch_valid_i;
    logic                         csr_valid_i;
    logic                         mult_valid_i;
    logic                         csr_commit_i;
    wb_t                          flu_wb_o;
    logic                         flu_ready_o;
    bp_resolve_t                  resolved_branch_o;
    logic                         resolve_branch_o;
    exception_t                   flu_exception_o;
    logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o;

    // Model state
    logic                         csr_full_m;
    logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_m;
    logic                         mult_pending;
    logic [`EX_XLEN-1:0]          mult_result_m;
    logic [`EX_TRANS_ID_BITS-1:0] mult_id_m;

    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          tests_done;

    ex_stage u_dut (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .fu_data_i         (fu_data_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_predict_i  (branch_predict_i),
        .alu_valid_i       (alu_valid_i),
        .branch_valid_i    (branch_valid_i),
        .csr_valid_i       (csr_valid_i),
        .mult_valid_i      (mult_valid_i),
        .csr_commit_i      (csr_commit_i),
        .flu_wb_o          (flu_wb_o),
        .flu_ready_o       (flu_ready_o),
        .resolved_branch_o (resolved_branch_o),
        .resolve_branch_o  (resolve_branch_o),
        .flu_exception_o   (flu_exception_o),
        .csr_addr_o        (csr_addr_o)
    );

    // Clock and reset come from the testbench top
    bind ex_flu_ctrl ex_stage_checker u_checker (
        .clk_i          (tb_ex_stage.clk_i),
        .reset_i        (tb_ex_stage.reset_i),
        .flush_i        (tb_ex_stage.flush_i),
        .alu_valid_i    (alu_valid_i),
        .branch_valid_i (branch_valid_i),
        .csr_valid_i    (csr_valid_i),
        .mult_valid_i   (mult_valid_i),
        .flu_ready_o    (flu_ready_o),
        .fu_data_i      (fu_data_i),
        .flu_wb_o       (flu_wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog, twice the expected run length
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("Watchdog expired after %0d cycles, the run did not finish", 2 * TOTAL_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------
    // Random source and models
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] alu_model(input fu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            // Arithmetic shift copies the sign bit in from the left
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            SLT:     return 32'($signed(a) < $signed(b));
            SLTU:    return 32'(a < b);
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic branch_model(input fu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LT:      return $signed(a) < $signed(b);
            GE:      return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ------------------------------
    // Checking and reporting
    // ------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-8s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // ------------------------------
    // One clock cycle
    // ------------------------------
    // Entered at a falling edge, drives, checks the settled outputs, updates the model
    task automatic cycle(input int kind, input logic commit, input logic flush);
        logic [31:0]                  r;
        logic                         taken;
        logic [`EX_XLEN-1:0]          link;
        logic [`EX_XLEN-1:0]          target;
        logic                         exp_valid;
        logic [`EX_XLEN-1:0]          exp_result;
        logic [`EX_TRANS_ID_BITS-1:0] exp_id;
        logic                         exp_exc;
        check_value("flu_ready_o", 32'(flu_ready_o), 32'(!(csr_full_m || mult_pending)));
        r = next_rand();
        fu_data_i.operand_a = next_rand();
        // Equal operands now and then so EQ and GE see both outcomes
        fu_data_i.operand_b = (r[3:2] == 2'b00) ? fu_data_i.operand_a : next_rand();
        fu_data_i.imm       = next_rand();
        fu_data_i.trans_id  = r[6:4];
        pc_i                = next_rand() & 32'hffff_fffe;
        is_compressed_i     = r[7];
        case (kind)
            K_ALU:   fu_data_i.operation = fu_op_t'(5'(r[31:16] % 16'd10));
            K_BR:    fu_data_i.operation = fu_op_t'(5'(r[31:16] % 16'd6 + 16'd10));
            K_CSR:   fu_data_i.operation = CSRRW;
            K_MUL:   fu_data_i.operation = MUL;
            default: fu_data_i.operation = ADD;
        endcase
        taken  = branch_model(fu_data_i.operation, fu_data_i.operand_a, fu_data_i.operand_b);
        link   = pc_i + (is_compressed_i ? `EX_XLEN'(2) : `EX_XLEN'(4));
        target = taken ? pc_i + fu_data_i.imm : link;
        // Half the predictions carry the right target
        branch_predict_i.predict_taken   = r[8];
        branch_predict_i.predict_address = r[9] ? target : next_rand();
        alu_valid_i    = kind == K_ALU;
        branch_valid_i = kind == K_BR;
        csr_valid_i    = kind == K_CSR;
        mult_valid_i   = kind == K_MUL;
        csr_commit_i   = commit;
        flush_i        = flush;
        #SETTLE;

        // Write-back port
        exp_valid = mult_pending || kind == K_ALU || kind == K_BR || kind == K_CSR;
        exp_id    = mult_pending ? mult_id_m : fu_data_i.trans_id;
        if (mult_pending) begin
            exp_result = mult_result_m;
        end else if (kind == K_ALU) begin
            exp_result = alu_model(fu_data_i.operation, fu_data_i.operand_a, fu_data_i.operand_b);
        end else if (kind == K_CSR) begin
            exp_result = fu_data_i.operand_a;
        end else begin
            exp_result = link;
        end
        check_value("wb valid", 32'(flu_wb_o.valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value("wb result", flu_wb_o.result, exp_result);
            check_value("wb trans_id", 32'(flu_wb_o.trans_id), 32'(exp_id));
        end

        // Branch resolution and misaligned target
        check_value("resolve_branch_o", 32'(resolve_branch_o), 32'(kind == K_BR));
        check_value("branch valid", 32'(resolved_branch_o.valid), 32'(kind == K_BR));
        exp_exc = kind == K_BR && taken && target[0];
        check_value("exception valid", 32'(flu_exception_o.valid), 32'(exp_exc));
        if (exp_exc) begin
            check_value("exception cause", 32'(flu_exception_o.cause), 32'd0);
            check_value("exception tval", flu_exception_o.tval, target);
        end
        if (kind == K_BR) begin
            check_value("branch pc", resolved_branch_o.pc, pc_i);
            check_value("branch target", resolved_branch_o.target_address, target);
            check_value("branch taken", 32'(resolved_branch_o.is_taken), 32'(taken));
            check_value("branch mispredict", 32'(resolved_branch_o.is_mispredict),
                        32'(branch_predict_i.predict_taken != taken
                            || branch_predict_i.predict_address != target));
        end
        if (csr_full_m) begin
            check_value("csr_addr_o", 32'(csr_addr_o), 32'(csr_addr_m));
        end

        // Model state for the next cycle
        mult_pending = kind == K_MUL && !flush;
        if (kind == K_MUL) begin
            mult_result_m = fu_data_i.operand_a * fu_data_i.operand_b;
            mult_id_m     = fu_data_i.trans_id;
        end
        if (flush || commit) begin
            csr_full_m = 1'b0;
        end else if (kind == K_CSR) begin
            csr_full_m = 1'b1;
            csr_addr_m = fu_data_i.operand_b[`EX_CSR_ADDR_BITS-1:0];
        end
        @(negedge clk_i);
    endtask

    // Idle cycles until the DUT takes issues again
    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!flu_ready_o && waited < READY_LIMIT) begin
            cycle(K_IDLE, 1'b0, 1'b0);
            waited++;
        end
        if (!flu_ready_o) begin
            errors++;
            test_errors++;
            $display("flu_ready_o stayed low for %0d cycles at time %0t", READY_LIMIT, $time);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int kind;
        logic [31:0] r;
        rng_state = 32'h5135_68b6;
        {checks, errors, test_checks, test_errors, tests_done} = '0;
        {csr_full_m, mult_pending} = 2'b00;
        csr_addr_m = '0;
        mult_result_m = '0;
        mult_id_m = '0;
        fu_data_i = '0;
        pc_i = '0;
        is_compressed_i = 1'b0;
        branch_predict_i = '0;
        {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} = 4'b0000;
        {csr_commit_i, flush_i} = 2'b00;
        reset_i = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        // One quiet cycle after reset
        @(negedge clk_i);

        repeat (N_ALU) begin
            wait_ready();
            cycle(K_ALU, 1'b0, 1'b0);
        end
        end_test("alu");

        repeat (N_BR) begin
            wait_ready();
            cycle(K_BR, 1'b0, 1'b0);
        end
        end_test("branch");

        // Write-back cycle expects ready low and the delayed product
        repeat (N_MUL) begin
            wait_ready();
            cycle(K_MUL, 1'b0, 1'b0);
            cycle(K_IDLE, 1'b0, 1'b0);
        end
        end_test("mult");

        repeat (N_CSR) begin
            wait_ready();
            cycle(K_CSR, 1'b0, 1'b0);
            repeat (1 + next_rand() % 3) cycle(K_IDLE, 1'b0, 1'b0);
            cycle(K_IDLE, 1'b1, 1'b0);
            check_value("ready after commit", 32'(flu_ready_o), 32'd1);
        end
        end_test("csr");

        repeat (N_FLUSH) begin
            wait_ready();
            cycle(K_MUL, 1'b0, 1'b1);
            // Killed multiply leaves the port idle
            cycle(K_IDLE, 1'b0, 1'b0);
            cycle(K_CSR, 1'b0, 1'b0);
            cycle(K_IDLE, 1'b0, 1'b1);
            check_value("ready after flush", 32'(flu_ready_o), 32'd1);
        end
        end_test("flush");

        // Issue only on DUT ready, commit only while blocked, rare flush
        repeat (N_MIX) begin
            r = next_rand();
            kind = flu_ready_o ? int'(r % 5) : K_IDLE;
            cycle(kind, !flu_ready_o && r[9:8] == 2'b00, r[15:10] == 6'd0);
        end
        end_test("mixed");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/ex_types_pkg.sv
design/ex_branch_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_csr_buffer.sv
design/ex_mult.sv
design/ex_flu_ctrl.sv
design/ex_stage.sv
dv/ex_stage_checker.sv
dv/tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f --top-module tb_ex_stage -o sim_ex_stage
then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ex_stage)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "Simulation output has no pass message"
exit 1
